// ==== Bender.yml ====
package:
  name: mdu

sources:
  - verilog/mdu_pkg.sv
  - verilog/mdu_div_step.sv
  - verilog/mdu_decode.sv
  - verilog/mdu_multiplier.sv
  - verilog/mdu_div_pipe.sv
  - verilog/mdu_result.sv
  - verilog/mdu_top.sv
  - target: test
    files:
      - dv/mdu_assertions.sv
      - dv/mdu_tb.sv

// ==== dv/mdu_assertions.sv ====
// Concurrent handshake and reset checks bound into every mdu_top instance.
`timescale 1ns/1ps

module mdu_assertions (
    input logic                     clk,
    input logic                     rst,
    input logic                     in_ready,
    input logic                     out_valid,
    input logic                     out_ready,
    input logic [mdu_pkg::XLEN-1:0] out_result
);

    // Failed assertion count.
    int error_count = 0;

    // A stalled result holds its value.
    a_result_held: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_result)
    ) else begin
        error_count++;
        $error("out_result changed while the result was stalled");
    end

    // Input side accepts exactly when the pipe advances.
    a_ready_rule: assert property (
        @(posedge clk) disable iff (rst)
        in_ready == (out_ready || !out_valid)
    ) else begin
        error_count++;
        $error("in_ready does not follow out_ready or not out_valid");
    end

    // No result in the cycle after reset.
    a_reset_idle: assert property (
        @(posedge clk)
        rst |=> !out_valid
    ) else begin
        error_count++;
        $error("out_valid high in the cycle after reset");
    end

endmodule

bind mdu_top mdu_assertions assertions_i (
    .clk        (clk),
    .rst        (rst),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
);

// ==== dv/mdu_tb.sv ====
// Self-checking testbench for mdu_top; LFSR stimulus, reference model and in-order scoreboard.
`timescale 1ns/1ps

module mdu_tb;

    localparam int CLK_PERIOD = 100;
    // Requests issued over all tests for the watchdog.
    localparam int TOTAL_REQS = 1214;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 20 + 1000;
    // Back-to-back burst length.
    localparam int BURST = 50;

    logic                     clk;
    logic                     rst;
    logic                     in_valid;
    logic                     in_ready;
    mdu_pkg::mdu_req_t        in_req;
    logic                     out_valid;
    logic                     out_ready;
    logic [mdu_pkg::XLEN-1:0] out_result;

    logic [31:0]              lfsr;
    mdu_pkg::mdu_req_t        pending [$];
    int                       cycle = 0;
    int                       test_errors;
    int                       pass_count;
    int                       fail_count;
    bit                       random_ready;
    bit                       track_latency;
    int                       first_acc_cycle;
    int                       last_acc_cycle;
    int                       first_out_cycle;
    logic [31:0]              corners [5] = '{32'h0, 32'h1, 32'hffff_ffff,
                                              32'h8000_0000, 32'h7fff_ffff};

    mdu_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_req     (in_req),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Edge count, read before the edge updates it.
    always @(posedge clk) cycle <= cycle + 1;

    // Fibonacci LFSR with taps 32 22 2 1.
    // One step for every bit handed out.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Family 0 multiplies, 1 divides, 2 any opcode.
    function automatic mdu_pkg::mdu_op_e random_op(input int family);
        logic [31:0] bits;
        if (family == 2) begin
            bits = take_bits(3);
            return mdu_pkg::mdu_op_e'(bits[2:0]);
        end
        bits = take_bits(2);
        return mdu_pkg::mdu_op_e'({family[0], bits[1:0]});
    endfunction

    // Half full-range values, half shifted down to small magnitudes.
    function automatic logic [31:0] random_operand();
        logic [31:0] v;
        logic [31:0] sh;
        v  = take_bits(32);
        sh = take_bits(5);
        if (sh[4]) return v;
        return v >> sh[3:0];
    endfunction

    // Reference result per the M extension in 64-bit arithmetic.
    function automatic logic [31:0] mdu_model(input mdu_pkg::mdu_op_e op,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ua;
        logic signed [63:0] ub;
        logic [63:0]        p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'h0, a};
        ub = {32'h0, b};
        case (op)
            mdu_pkg::OP_MUL:    p = sa * sb;
            mdu_pkg::OP_MULH:   p = (sa * sb) >> 32;
            mdu_pkg::OP_MULHSU: p = (sa * ub) >> 32;
            mdu_pkg::OP_MULHU:  p = (ua * ub) >> 32;
            // Truncating division wraps MIN / -1 back to MIN.
            mdu_pkg::OP_DIV:    p = sa / sb;
            mdu_pkg::OP_DIVU:   p = ua / ub;
            // Remainder carries the dividend's sign.
            mdu_pkg::OP_REM:    p = sa % sb;
            default:            p = ua % ub;
        endcase
        // Zero divisor gives all ones, or the dividend for remainders.
        if (b == 32'h0 && op[2]) p = op[1] ? {32'h0, a} : '1;
        return p[31:0];
    endfunction

    // One clock with no request; random out_ready when enabled.
    task automatic idle();
        @(posedge clk);
        #1;
        if (random_ready) out_ready = (take_bits(1) != 0);
    endtask

    // Present a request until accepted and log it for the scoreboard.
    task automatic send(input mdu_pkg::mdu_op_e op, input logic [31:0] a, input logic [31:0] b);
        bit acc;
        acc       = 1'b0;
        in_valid  = 1'b1;
        in_req.op = op;
        in_req.a  = a;
        in_req.b  = b;
        while (!acc) begin
            @(posedge clk);
            acc = in_ready;
            if (acc) begin
                pending.push_back(in_req);
                if (track_latency && first_acc_cycle < 0) first_acc_cycle = cycle;
                if (track_latency) last_acc_cycle = cycle;
            end
            #1;
            if (random_ready) out_ready = (take_bits(1) != 0);
        end
        in_valid = 1'b0;
    endtask

    // Every corner pair under four opcodes from first_op up.
    task automatic send_corners(input int first_op);
        foreach (corners[i]) begin
            foreach (corners[j]) begin
                for (int k = first_op; k < first_op + 4; k++) begin
                    send(mdu_pkg::mdu_op_e'(3'(k)), corners[i], corners[j]);
                end
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < 500) begin
            idle();
            waited++;
        end
    endtask

    // Waits out the last results and scores the test.
    task automatic finish_test(input string name);
        drain();
        if (pending.size() != 0) begin
            $display("Error at %0t: %0d results never came out", $time, pending.size());
            test_errors++;
            pending.delete();
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("Test %s: PASS", name);
        end else begin
            fail_count++;
            $display("Test %s: FAIL with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // Scoreboard pops one request per output transfer.
    always @(posedge clk) begin
        mdu_pkg::mdu_req_t req;
        logic [31:0]       exp;
        if (!rst && out_valid && out_ready) begin
            if (track_latency && first_out_cycle < 0) first_out_cycle = cycle;
            if (pending.size() == 0) begin
                $display("Error at %0t: extra result %h with no request outstanding",
                         $time, out_result);
                test_errors++;
            end else begin
                req = pending.pop_front();
                exp = mdu_model(req.op, req.a, req.b);
                if (out_result !== exp) begin
                    $display("Mismatch at %0t: %s a=%h b=%h expected %h got %h",
                             $time, req.op.name(), req.a, req.b, exp, out_result);
                    test_errors++;
                end
            end
        end
    end

    initial begin
        lfsr            = 32'h55b6;
        rst             = 1'b1;
        in_valid        = 1'b0;
        in_req          = '0;
        out_ready       = 1'b1;
        random_ready    = 1'b0;
        track_latency   = 1'b0;
        first_acc_cycle = -1;
        last_acc_cycle  = -1;
        first_out_cycle = -1;
        test_errors     = 0;
        pass_count      = 0;
        fail_count      = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 300; i++) send(random_op(0), random_operand(), random_operand());
        send_corners(0);
        finish_test("multiply family");

        for (int i = 0; i < 300; i++) send(random_op(1), random_operand(), random_operand());
        send_corners(4);
        finish_test("divide family");

        // Zero divisors and the one signed overflow case.
        foreach (corners[i]) begin
            for (int k = 4; k < 8; k++) send(mdu_pkg::mdu_op_e'(3'(k)), corners[i], 32'h0);
        end
        for (int k = 4; k < 8; k++) send(mdu_pkg::mdu_op_e'(3'(k)), 32'h8000_0000, 32'hffff_ffff);
        finish_test("special divides");

        // Back to back with the sink always ready.
        track_latency = 1'b1;
        for (int i = 0; i < BURST; i++) send(random_op(2), random_operand(), random_operand());
        drain();
        if (first_out_cycle - first_acc_cycle != mdu_pkg::LATENCY) begin
            $display("Mismatch at %0t: latency expected %0d cycles got %0d",
                     $time, mdu_pkg::LATENCY, first_out_cycle - first_acc_cycle);
            test_errors++;
        end
        // One request taken on every edge of the burst.
        if (last_acc_cycle - first_acc_cycle != BURST - 1) begin
            $display("Mismatch at %0t: burst expected %0d cycles got %0d",
                     $time, BURST, last_acc_cycle - first_acc_cycle + 1);
            test_errors++;
        end
        track_latency = 1'b0;
        finish_test("throughput and latency");

        // Random gaps on both sides of the pipe.
        random_ready = 1'b1;
        for (int i = 0; i < 300; i++) begin
            while (take_bits(1) == 0) idle();
            send(random_op(2), random_operand(), random_operand());
        end
        finish_test("back-pressure");
        random_ready = 1'b0;
        out_ready    = 1'b1;

        // Reset lands with ops still in flight.
        for (int i = 0; i < 10; i++) send(random_op(2), random_operand(), random_operand());
        rst = 1'b1;
        pending.delete();
        repeat (3) idle();
        if (out_valid !== 1'b0) begin
            $display("Mismatch at %0t: out_valid expected 0 during reset got %b",
                     $time, out_valid);
            test_errors++;
        end
        rst = 1'b0;
        for (int i = 0; i < 30; i++) send(random_op(2), random_operand(), random_operand());
        finish_test("reset mid-stream");

        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 pass_count, fail_count, dut_i.assertions_i.error_count);
        if (fail_count == 0 && dut_i.assertions_i.error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog against a stuck handshake.
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/mdu_pkg.sv
verilog/mdu_div_step.sv
verilog/mdu_decode.sv
verilog/mdu_multiplier.sv
verilog/mdu_div_pipe.sv
verilog/mdu_result.sv
verilog/mdu_top.sv
dv/mdu_assertions.sv
dv/mdu_tb.sv

// ==== verilog/mdu_decode.sv ====
// First pipeline stage; decodes the opcode and registers multiplier and divider operands.
`timescale 1ns/1ps

module mdu_decode (
    input  logic                     clk,
    input  logic                     advance,
    input  mdu_pkg::mdu_req_t        in_req,
    output mdu_pkg::mdu_side_t       side,
    output mdu_pkg::mdu_div_t        div_state,
    output logic [mdu_pkg::XLEN:0]   mul_a,
    output logic [mdu_pkg::XLEN:0]   mul_b
);

    logic                     a_signed;
    logic                     b_signed;
    logic                     a_neg;
    logic                     b_neg;
    logic [mdu_pkg::XLEN-1:0] a_mag;
    logic [mdu_pkg::XLEN-1:0] b_mag;
    logic                     b_zero;
    mdu_pkg::mdu_side_t       side_d;
    mdu_pkg::mdu_div_t        div_d;

    // Operand a is signed for MULH, MULHSU, DIV and REM.
    assign a_signed = (in_req.op == mdu_pkg::OP_MULH)   ||
                      (in_req.op == mdu_pkg::OP_MULHSU) ||
                      (in_req.op == mdu_pkg::OP_DIV)    ||
                      (in_req.op == mdu_pkg::OP_REM);

    // Operand b is signed for MULH, DIV and REM only.
    assign b_signed = (in_req.op == mdu_pkg::OP_MULH) ||
                      (in_req.op == mdu_pkg::OP_DIV)  ||
                      (in_req.op == mdu_pkg::OP_REM);

    assign a_neg  = a_signed && in_req.a[mdu_pkg::XLEN-1];
    assign b_neg  = b_signed && in_req.b[mdu_pkg::XLEN-1];
    assign b_zero = (in_req.b == '0);

    // Magnitudes; the most negative value maps onto itself, read as unsigned.
    assign a_mag = a_neg ? (~in_req.a + 1'b1) : in_req.a;
    assign b_mag = b_neg ? (~in_req.b + 1'b1) : in_req.b;

    always_comb begin
        side_d          = '0;
        side_d.op       = in_req.op;
        // No sign flip on the all-ones quotient of a zero divisor.
        side_d.neg_q    = (a_neg ^ b_neg) && !b_zero;
        // Remainder takes the sign of the dividend.
        side_d.neg_r    = a_neg;
        side_d.div_zero = b_zero;
        side_d.dividend = in_req.a;
        div_d.divisor   = b_mag;
        div_d.remainder = a_mag;
        div_d.quotient  = '0;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            side      <= side_d;
            div_state <= div_d;
            // Sign or zero extension to 33 bits for one signed multiplier.
            mul_a     <= {a_neg, in_req.a};
            mul_b     <= {b_neg, in_req.b};
        end
    end

endmodule

// ==== verilog/mdu_div_pipe.sv ====
// Chain of restoring division steps in registered groups, sideband kept in step.
`timescale 1ns/1ps

module mdu_div_pipe (
    input  logic               clk,
    input  logic               advance,
    input  mdu_pkg::mdu_div_t  div_in,
    input  mdu_pkg::mdu_side_t side_in,
    output mdu_pkg::mdu_div_t  div_out,
    output mdu_pkg::mdu_side_t side_out
);

    // Division state between steps.
    mdu_pkg::mdu_div_t  chain [mdu_pkg::XLEN+1];

    // Sideband at the start of each group.
    mdu_pkg::mdu_side_t side_chain [mdu_pkg::DIV_STAGES];

    assign chain[0] = div_in;

    // Step i resolves quotient bit XLEN-1-i, MSB first.
    // First step of every later group carries the register.
    generate
        for (genvar i = 0; i < mdu_pkg::XLEN; i++) begin : g_step
            mdu_div_step #(
                .bit_index (mdu_pkg::XLEN - 1 - i),
                .has_reg   ((i != 0) && (i % mdu_pkg::STEPS_PER_STAGE == 0))
            ) step_i (
                .clk     (clk),
                .advance (advance),
                .d       (chain[i]),
                .q       (chain[i+1])
            );
        end
    endgenerate

    assign div_out = chain[mdu_pkg::XLEN];

    // Group 0 shares the sideband entering the pipe.
    assign side_chain[0] = side_in;

    // One sideband register per group register above.
    generate
        for (genvar g = 1; g < mdu_pkg::DIV_STAGES; g++) begin : g_side
            always_ff @(posedge clk) begin
                if (advance) begin
                    side_chain[g] <= side_chain[g-1];
                end
            end
        end
    endgenerate

    // Sideband of the op now leaving the last step.
    assign side_out = side_chain[mdu_pkg::DIV_STAGES-1];

endmodule

// ==== verilog/mdu_div_step.sv ====
// One restoring division step resolving a single quotient bit, optionally registered.
`timescale 1ns/1ps

module mdu_div_step #(
    // Quotient bit resolved here.
    parameter int bit_index = 0,
    // Pipeline register on the input.
    parameter bit has_reg   = 1'b0
) (
    input  logic              clk,
    input  logic              advance,
    input  mdu_pkg::mdu_div_t d,
    output mdu_pkg::mdu_div_t q
);

    mdu_pkg::mdu_div_t          r;
    logic [2*mdu_pkg::XLEN-1:0] shifted;
    logic                       divisible;

    generate
        if (has_reg) begin : g_reg
            always_ff @(posedge clk) begin
                if (advance) begin
                    r <= d;
                end
            end
        end else begin : g_comb
            assign r = d;
        end
    endgenerate

    always_comb begin
        // Double width so divisor bits shifted past XLEN still count.
        shifted    = {{mdu_pkg::XLEN{1'b0}}, r.divisor} << bit_index;
        divisible  = {{mdu_pkg::XLEN{1'b0}}, r.remainder} >= shifted;
        q          = r;
        if (divisible) begin
            q.remainder = r.remainder - shifted[mdu_pkg::XLEN-1:0];
        end
        // Quotient starts at zero, so or-ing in the bit sets it.
        q.quotient = r.quotient | ({{(mdu_pkg::XLEN-1){1'b0}}, divisible} << bit_index);
    end

endmodule

// ==== verilog/mdu_multiplier.sv ====
// Registered 33x33 signed multiplier covering MUL, MULH, MULHSU and MULHU.
`timescale 1ns/1ps

module mdu_multiplier (
    input  logic                       clk,
    input  logic                       advance,
    input  mdu_pkg::mdu_op_e           op,
    input  logic [mdu_pkg::XLEN:0]     mul_a,
    input  logic [mdu_pkg::XLEN:0]     mul_b,
    output logic [2*mdu_pkg::XLEN-1:0] product
);

    logic                              is_mul;
    logic signed [2*mdu_pkg::XLEN-1:0] full;

    // Multiply opcodes all have funct3 bit 2 clear.
    assign is_mul = (op == mdu_pkg::OP_MUL)    ||
                    (op == mdu_pkg::OP_MULH)   ||
                    (op == mdu_pkg::OP_MULHSU) ||
                    (op == mdu_pkg::OP_MULHU);

    // Extended operands make every variant one signed product.
    // Only the low 64 of the 66 product bits are ever used.
    // Synthesis infers the multiplier array.
    assign full = $signed(mul_a) * $signed(mul_b);

    // Product register.
    // Held on divide ops to save toggling, result picks quotient or remainder then.
    always_ff @(posedge clk) begin
        if (advance && is_mul) begin
            product <= full;
        end
    end

endmodule

// ==== verilog/mdu_pkg.sv ====
// Shared types and pipeline constants for the M-extension multiply/divide unit.
package mdu_pkg;

    // Operand and result width.
    localparam int XLEN = 32;

    // Registered groups in the restoring divider.
    localparam int DIV_STAGES = 4;

    // Quotient bits resolved per divider group.
    localparam int STEPS_PER_STAGE = XLEN / DIV_STAGES;

    // Decode register, divider group registers and output register.
    localparam int LATENCY = DIV_STAGES + 2;

    // Opcodes, encoded as the funct3 field of the M extension.
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } mdu_op_e;

    // One request on the input stream.
    typedef struct packed {
        mdu_op_e           op;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
    } mdu_req_t;

    // Per-operation sideband that follows the divider data.
    typedef struct packed {
        mdu_op_e           op;
        // Negate the quotient magnitude.
        logic              neg_q;
        // Negate the remainder magnitude.
        logic              neg_r;
        logic              div_zero;
        // Original a, used as the remainder on a zero divisor.
        logic [XLEN-1:0]   dividend;
        // Low 64 bits of the product, filled in after decode.
        logic [2*XLEN-1:0] product;
    } mdu_side_t;

    // Restoring division working state.
    typedef struct packed {
        logic [XLEN-1:0]   divisor;
        logic [XLEN-1:0]   remainder;
        logic [XLEN-1:0]   quotient;
    } mdu_div_t;

endpackage

// ==== verilog/mdu_result.sv ====
// Final stage; sign-corrects the divider output, picks the result and registers it.
`timescale 1ns/1ps

module mdu_result (
    input  logic                     clk,
    input  logic                     advance,
    input  mdu_pkg::mdu_div_t        div_in,
    input  mdu_pkg::mdu_side_t       side_in,
    output logic [mdu_pkg::XLEN-1:0] out_result
);

    logic [mdu_pkg::XLEN-1:0] quot;
    logic [mdu_pkg::XLEN-1:0] rem;
    logic [mdu_pkg::XLEN-1:0] result_d;

    // Quotient.
    // MIN / -1 lands on MIN here with no special handling.
    always_comb begin
        if (side_in.div_zero) begin
            quot = '1;
        end else if (side_in.neg_q) begin
            quot = ~div_in.quotient + 1'b1;
        end else begin
            quot = div_in.quotient;
        end
    end

    // Remainder, with the dividend's sign.
    always_comb begin
        if (side_in.div_zero) begin
            rem = side_in.dividend;
        end else if (side_in.neg_r) begin
            rem = ~div_in.remainder + 1'b1;
        end else begin
            rem = div_in.remainder;
        end
    end

    // Result select.
    always_comb begin
        case (side_in.op)
            mdu_pkg::OP_MUL:    result_d = side_in.product[mdu_pkg::XLEN-1:0];
            mdu_pkg::OP_MULH,
            mdu_pkg::OP_MULHSU,
            mdu_pkg::OP_MULHU:  result_d = side_in.product[2*mdu_pkg::XLEN-1:mdu_pkg::XLEN];
            mdu_pkg::OP_DIV,
            mdu_pkg::OP_DIVU:   result_d = quot;
            default:            result_d = rem;
        endcase
    end

    // Output register, frozen while the consumer stalls.
    always_ff @(posedge clk) begin
        if (advance) begin
            out_result <= result_d;
        end
    end

endmodule

// ==== verilog/mdu_top.sv ====
// Top of the multiply/divide unit; valid/ready streams around a fixed-latency pipeline.
`timescale 1ns/1ps

module mdu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  mdu_pkg::mdu_req_t        in_req,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [mdu_pkg::XLEN-1:0] out_result
);

    logic                          advance;
    logic [mdu_pkg::LATENCY-1:0]   valid_sr;
    mdu_pkg::mdu_side_t            dec_side;
    mdu_pkg::mdu_div_t             dec_div;
    logic [mdu_pkg::XLEN:0]        mul_a;
    logic [mdu_pkg::XLEN:0]        mul_b;
    logic [2*mdu_pkg::XLEN-1:0]    product;
    mdu_pkg::mdu_side_t            entry_side;
    mdu_pkg::mdu_div_t             entry_div;
    mdu_pkg::mdu_side_t            pipe_side;
    mdu_pkg::mdu_div_t             pipe_div_out;
    mdu_pkg::mdu_side_t            pipe_side_out;

    // Whole pipe moves unless the output holds an unaccepted result.
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;

    // Valid bits shadow the data registers one for one.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else if (advance) begin
            valid_sr <= {valid_sr[mdu_pkg::LATENCY-2:0], in_valid};
        end
    end
    assign out_valid = valid_sr[mdu_pkg::LATENCY-1];

    mdu_decode decode_i (
        .clk (clk), .advance (advance), .in_req (in_req),
        .side (dec_side), .div_state (dec_div), .mul_a (mul_a), .mul_b (mul_b)
    );

    mdu_multiplier mul_i (
        .clk (clk), .advance (advance), .op (dec_side.op),
        .mul_a (mul_a), .mul_b (mul_b), .product (product)
    );

    // First divider group input, loaded with the product register.
    always_ff @(posedge clk) begin
        if (advance) begin
            entry_side <= dec_side;
            entry_div  <= dec_div;
        end
    end

    // Product joins the sideband here, already aligned.
    always_comb begin
        pipe_side         = entry_side;
        pipe_side.product = product;
    end

    mdu_div_pipe div_pipe_i (
        .clk (clk), .advance (advance), .div_in (entry_div), .side_in (pipe_side),
        .div_out (pipe_div_out), .side_out (pipe_side_out)
    );

    mdu_result result_i (
        .clk (clk), .advance (advance), .div_in (pipe_div_out),
        .side_in (pipe_side_out), .out_result (out_result)
    );

endmodule
